/* hdl/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Register word width
`define DATA_WIDTH 16

// Registers in the file, register 0 included
`define REG_COUNT 16

// Bits needed to name one register
`define REG_ID_WIDTH 4

`endif

/* hdl/corePkg.sv */
`include "core_cfg.svh"

package corePkg;

	typedef logic [`DATA_WIDTH-1:0]          wordT;
	typedef logic [`REG_ID_WIDTH-1:0]        regIdT;
	typedef logic [3:0]                      opcodeT;
	typedef logic [7:0]                      imm8T;   // Byte for LLB and LHB
	typedef logic [$clog2(`DATA_WIDTH)-1:0]  shamtT;  // Shift or rotate distance

	// Register ops
	localparam opcodeT OP_ADD = 4'h0;
	localparam opcodeT OP_SUB = 4'h1;
	localparam opcodeT OP_XOR = 4'h2;
	localparam opcodeT OP_AND = 4'h3;

	// Immediate shifts
	localparam opcodeT OP_SLL = 4'h4;
	localparam opcodeT OP_SRA = 4'h5;
	localparam opcodeT OP_ROR = 4'h6;

	// Byte loads merging into rd
	localparam opcodeT OP_LLB = 4'h7;
	localparam opcodeT OP_LHB = 4'h8;

	// Codes 9 to 15 are no-ops

endpackage

/* hdl/registerFile.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module registerFile (
	input  logic           clk,
	input  logic           rstN,
	input  corePkg::regIdT srcReg1,
	input  corePkg::regIdT srcReg2,
	input  logic           wbValid,
	input  corePkg::regIdT wbDst,
	input  corePkg::wordT  wbData,
	output corePkg::wordT  srcData1,
	output corePkg::wordT  srcData2
);
	import corePkg::*;

	wordT                  regs [1:`REG_COUNT-1];  // No storage for register 0
	logic [`REG_COUNT-1:1] writeEn;
	logic [`REG_COUNT-1:1] readSel1;
	logic [`REG_COUNT-1:1] readSel2;
	wordT                  rawData1;
	wordT                  rawData2;
	logic                  fwdHit1;
	logic                  fwdHit2;

	// One-hot select over registers 1 to 15, id 0 gives all zero
	function automatic logic [`REG_COUNT-1:1] oneHot(regIdT id);
		logic [`REG_COUNT-1:1] sel;
		for (int i = 1; i < `REG_COUNT; i++) begin
			sel[i] = (id == regIdT'(i));
		end
		return sel;
	endfunction

	assign writeEn  = oneHot(wbDst) & {(`REG_COUNT-1){wbValid}};
	assign readSel1 = oneHot(srcReg1);
	assign readSel2 = oneHot(srcReg2);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 1; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 1; i < `REG_COUNT; i++) begin
				if (writeEn[i]) begin
					regs[i] <= wbData;
				end
			end
		end
	end

	// AND-OR mux in place of shared bitlines
	always_comb begin
		rawData1 = '0;
		rawData2 = '0;
		for (int i = 1; i < `REG_COUNT; i++) begin
			rawData1 = rawData1 | (regs[i] & {`DATA_WIDTH{readSel1[i]}});
			rawData2 = rawData2 | (regs[i] & {`DATA_WIDTH{readSel2[i]}});
		end
	end

	// Write and read select on the same nonzero register
	assign fwdHit1 = |(writeEn & readSel1);
	assign fwdHit2 = |(writeEn & readSel2);

	assign srcData1 = fwdHit1 ? wbData : rawData1;  // Bypass the pending write
	assign srcData2 = fwdHit2 ? wbData : rawData2;

endmodule

/* hdl/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
	input  logic            instrValid,
	input  corePkg::wordT   instr,
	output corePkg::regIdT  srcReg1,
	output corePkg::regIdT  srcReg2,
	output corePkg::regIdT  dstReg,
	output corePkg::opcodeT opcode,
	output corePkg::imm8T   imm8,
	output corePkg::shamtT  shamt,
	output logic            writes
);
	import corePkg::*;

	regIdT rsField;
	regIdT rtField;
	logic  byteLoad;
	logic  writesOp;

	// Fixed field positions
	assign opcode  = instr[15:12];
	assign dstReg  = instr[11:8];
	assign rsField = instr[7:4];
	assign rtField = instr[3:0];
	assign imm8    = instr[7:0];
	assign shamt   = instr[3:0];  // Shares bits with rt

	always_comb begin
		case (opcode)
			OP_ADD, OP_SUB, OP_XOR, OP_AND: begin
				writesOp = 1'b1;
				byteLoad = 1'b0;
			end
			OP_SLL, OP_SRA, OP_ROR: begin
				writesOp = 1'b1;
				byteLoad = 1'b0;
			end
			OP_LLB, OP_LHB: begin
				writesOp = 1'b1;
				byteLoad = 1'b1;  // Needs old rd for the kept half
			end
			default: begin
				writesOp = 1'b0;  // No-op space
				byteLoad = 1'b0;
			end
		endcase
	end

	// Port 1 reads rd for byte merges
	assign srcReg1 = byteLoad ? dstReg : rsField;
	assign srcReg2 = rtField;

	assign writes = instrValid & writesOp;

endmodule

/* hdl/execUnit.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module execUnit (
	input  logic            clk,
	input  logic            rstN,
	input  corePkg::opcodeT opcode,
	input  corePkg::regIdT  dstReg,
	input  corePkg::imm8T   imm8,
	input  corePkg::shamtT  shamt,
	input  logic            writes,
	input  corePkg::wordT   srcData1,
	input  corePkg::wordT   srcData2,
	output logic            wbValid,
	output corePkg::regIdT  wbDst,
	output corePkg::wordT   wbData
);
	import corePkg::*;

	wordT                     result;
	wordT                     rotated;
	logic [2*`DATA_WIDTH-1:0] rotPair;

	// Rotate via doubled operand, low half holds the result
	assign rotPair = {srcData1, srcData1} >> shamt;
	assign rotated = rotPair[`DATA_WIDTH-1:0];

	always_comb begin
		case (opcode)
			OP_ADD: begin
				result = srcData1 + srcData2;  // Wraps
			end
			OP_SUB: begin
				result = srcData1 - srcData2;
			end
			OP_XOR: begin
				result = srcData1 ^ srcData2;
			end
			OP_AND: begin
				result = srcData1 & srcData2;
			end
			OP_SLL: begin
				result = srcData1 << shamt;
			end
			OP_SRA: begin
				result = wordT'($signed(srcData1) >>> shamt);  // Sign fill
			end
			OP_ROR: begin
				result = rotated;
			end
			OP_LLB: begin
				result = {srcData1[`DATA_WIDTH-1:8], imm8};  // Keep upper byte of rd
			end
			OP_LHB: begin
				result = {imm8, srcData1[7:0]};  // Keep lower byte of rd
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// Writeback stage
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= writes;
		end
	end

	always_ff @(posedge clk) begin
		if (writes) begin
			wbDst  <= dstReg;
			wbData <= result;
		end
	end

endmodule

/* hdl/execCore.sv */
`timescale 1ns/1ps

module execCore (
	input  logic           clk,
	input  logic           rstN,
	input  logic           instrValid,
	input  corePkg::wordT  instr,
	output logic           wbValid,
	output corePkg::regIdT wbDst,
	output corePkg::wordT  wbData
);
	import corePkg::*;

	regIdT  srcReg1;
	regIdT  srcReg2;
	regIdT  dstReg;
	opcodeT opcode;
	imm8T   imm8;
	shamtT  shamt;
	logic   writes;
	wordT   srcData1;
	wordT   srcData2;

	instrDecode decode_i (
		.instrValid (instrValid),
		.instr      (instr),
		.srcReg1    (srcReg1),
		.srcReg2    (srcReg2),
		.dstReg     (dstReg),
		.opcode     (opcode),
		.imm8       (imm8),
		.shamt      (shamt),
		.writes     (writes)
	);

	// Write port fed from the writeback stage
	registerFile regFile_i (
		.clk      (clk),
		.rstN     (rstN),
		.srcReg1  (srcReg1),
		.srcReg2  (srcReg2),
		.wbValid  (wbValid),
		.wbDst    (wbDst),
		.wbData   (wbData),
		.srcData1 (srcData1),
		.srcData2 (srcData2)
	);

	execUnit exec_i (
		.clk      (clk),
		.rstN     (rstN),
		.opcode   (opcode),
		.dstReg   (dstReg),
		.imm8     (imm8),
		.shamt    (shamt),
		.writes   (writes),
		.srcData1 (srcData1),
		.srcData2 (srcData2),
		.wbValid  (wbValid),
		.wbDst    (wbDst),
		.wbData   (wbData)
	);

endmodule

/* testbench/execCoreTb.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module execCoreTb;
	import corePkg::*;

	localparam int RESET_CYCLES    = 3;
	localparam int IDLE_CYCLES     = 4;
	localparam int ZERO_ADDS       = 8;
	localparam int BYTE_CYCLES     = 2 * (`REG_COUNT - 1);
	localparam int ALU_PER_OP      = 8;
	localparam int ALU_CYCLES      = 4 * ALU_PER_OP;
	localparam int SHIFT_CYCLES    = 3 * `DATA_WIDTH;
	localparam int CHAIN_CYCLES    = 20;
	localparam int ZERO_REG_CYCLES = 4;
	localparam int RANDOM_CYCLES   = 300;
	localparam int DRAIN_CYCLES    = 4;
	localparam int TEST_CYCLES     = RESET_CYCLES + 1 + IDLE_CYCLES + ZERO_ADDS + BYTE_CYCLES
		+ ALU_CYCLES + SHIFT_CYCLES + CHAIN_CYCLES + ZERO_REG_CYCLES + RANDOM_CYCLES
		+ DRAIN_CYCLES + 3;
	localparam int MAX_CYCLES      = TEST_CYCLES + 50;

	typedef logic [`REG_ID_WIDTH+`DATA_WIDTH:0] expEntryT;  // {valid, dst, data}

	logic   clk;
	logic   rstN;
	logic   instrValid;
	wordT   instr;
	logic   wbValid;
	regIdT  wbDst;
	wordT   wbData;

	wordT        modelRegs [`REG_COUNT];
	expEntryT    expQ [$];
	expEntryT    pending;
	logic [31:0] lfsrState = 32'h8b0;
	int          cycleCount = 0;
	int          checks = 0;
	int          validErrors = 0;
	int          dstErrors = 0;
	int          dataErrors = 0;

	execCore dut_i (
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instr      (instr),
		.wbValid    (wbValid),
		.wbDst      (wbDst),
		.wbData     (wbData)
	);

	always #5 clk = ~clk;

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] takeBits(int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
		end
		return value;
	endfunction

	function automatic regIdT randReg();
		return regIdT'(takeBits(4));
	endfunction

	function automatic regIdT randNonZeroReg();
		regIdT id;
		id = randReg();
		if (id == 0) begin
			id = regIdT'(1);
		end
		return id;
	endfunction

	function automatic wordT makeInstr(opcodeT op, regIdT rd, regIdT rs, logic [3:0] low);
		return {op, rd, rs, low};
	endfunction

	function automatic wordT byteInstr(opcodeT op, regIdT rd, imm8T imm);
		return {op, rd, imm};
	endfunction

	// Expected result from the model registers
	function automatic wordT refResult(wordT ins);
		opcodeT op;
		regIdT  rd;
		wordT   a;
		wordT   b;
		wordT   r;
		int     sh;
		op = ins[15:12];
		rd = ins[11:8];
		a  = modelRegs[ins[7:4]];
		b  = modelRegs[ins[3:0]];
		sh = int'(ins[3:0]);
		r  = '0;
		case (op)
			OP_ADD: r = a + b;
			OP_SUB: r = a - b;
			OP_XOR: r = a ^ b;
			OP_AND: r = a & b;
			OP_SLL: r = a << sh;
			OP_SRA: begin
				r = a;
				for (int k = 0; k < sh; k++) begin
					r = {r[`DATA_WIDTH-1], r[`DATA_WIDTH-1:1]};  // One step keeping the sign
				end
			end
			OP_ROR: begin
				r = a;
				for (int k = 0; k < sh; k++) begin
					r = {r[0], r[`DATA_WIDTH-1:1]};
				end
			end
			OP_LLB: r = {modelRegs[rd][`DATA_WIDTH-1:8], ins[7:0]};
			OP_LHB: r = {ins[7:0], modelRegs[rd][7:0]};
			default: r = '0;
		endcase
		return r;
	endfunction

	// Drive one cycle and record what writeback should show next cycle
	task automatic issue(input logic valid, input wordT ins);
		logic  w;
		regIdT d;
		wordT  res;
		@(negedge clk);
		instrValid = valid;
		instr      = ins;
		w   = valid && (ins[15:12] <= OP_LHB);
		d   = ins[11:8];
		res = w ? refResult(ins) : '0;
		expQ.push_back({w, d, res});
		if (w && d != 0) begin
			modelRegs[d] = res;  // Register 0 stays zero
		end
	endtask

	task automatic checkWriteback(input expEntryT exp);
		logic  expValid;
		regIdT expDst;
		wordT  expData;
		{expValid, expDst, expData} = exp;
		checks++;
		assert (wbValid === expValid) else begin
			validErrors++;
			$display("error %0t: wbValid expected %b, actual %b", $time, expValid, wbValid);
		end
		if (expValid) begin
			assert (wbDst === expDst) else begin
				dstErrors++;
				$display("error %0t: wbDst expected %0d, actual %0d", $time, expDst, wbDst);
			end
			assert (wbData === expData) else begin
				dataErrors++;
				$display("error %0t: wbData expected %h, actual %h", $time, expData, wbData);
			end
		end
	endtask

	// Compare the instruction sampled one edge earlier
	always @(posedge clk) begin
		if (!rstN) begin
			assert (wbValid === 1'b0) else begin
				validErrors++;
				$display("error %0t: wbValid expected 0, actual %b in reset", $time, wbValid);
			end
			pending = '0;
		end else begin
			checkWriteback(pending);
			if (expQ.size() > 0) begin
				pending = expQ.pop_front();
			end else begin
				pending = '0;
			end
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic runResetChecks();
		repeat (IDLE_CYCLES) begin
			issue(1'b0, makeInstr(OP_ADD, randReg(), randReg(), randReg()));  // Ignored
		end
		repeat (ZERO_ADDS) begin
			issue(1'b1, makeInstr(OP_ADD, randReg(), randReg(), randReg()));
		end
	endtask

	task automatic loadByteConstants();
		for (int r = 1; r < `REG_COUNT; r++) begin
			issue(1'b1, byteInstr(OP_LLB, regIdT'(r), imm8T'(takeBits(8))));
			issue(1'b1, byteInstr(OP_LHB, regIdT'(r), imm8T'(takeBits(8))));  // Forwarded rd
		end
	endtask

	task automatic runAluOps();
		for (int k = 0; k < 4; k++) begin
			repeat (ALU_PER_OP) begin
				issue(1'b1, makeInstr(opcodeT'(k), randNonZeroReg(), randNonZeroReg(),
					randNonZeroReg()));
			end
		end
	endtask

	task automatic runShifts();
		for (int k = 0; k < 3; k++) begin
			for (int sh = 0; sh < `DATA_WIDTH; sh++) begin
				issue(1'b1, makeInstr(opcodeT'(4 + k), randNonZeroReg(), randNonZeroReg(),
					shamtT'(sh)));
			end
		end
	endtask

	task automatic runChain();
		regIdT      prev;
		regIdT      rd;
		opcodeT     op;
		logic [3:0] low;
		prev = randNonZeroReg();
		repeat (CHAIN_CYCLES) begin
			op = opcodeT'(takeBits(3) % 7);
			rd = randNonZeroReg();
			if (op >= OP_SLL) begin
				low = shamtT'(takeBits(4));
			end else begin
				low = (takeBits(1) != 0) ? prev : randReg();
			end
			issue(1'b1, makeInstr(op, rd, prev, low));
			prev = rd;
		end
	endtask

	task automatic runZeroReg();
		issue(1'b1, makeInstr(OP_ADD, regIdT'(0), regIdT'(1), regIdT'(2)));
		issue(1'b1, byteInstr(OP_LLB, regIdT'(0), 8'ha5));  // Old r0 still zero
		issue(1'b1, makeInstr(OP_ADD, regIdT'(3), regIdT'(0), regIdT'(0)));
		issue(1'b1, makeInstr(OP_XOR, regIdT'(4), regIdT'(0), regIdT'(5)));
	endtask

	task automatic runRandom();
		logic valid;
		repeat (RANDOM_CYCLES) begin
			valid = (takeBits(3) != 0);
			issue(valid, wordT'(takeBits(16)));
		end
	endtask

	initial begin
		clk        = 1'b0;
		rstN       = 1'b1;
		instrValid = 1'b0;
		instr      = '0;
		pending    = '0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			modelRegs[i] = '0;
		end
		#1;
		rstN = 1'b0;  // Clean falling edge once every process waits
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		runResetChecks();
		loadByteConstants();
		runAluOps();
		runShifts();
		runChain();
		runZeroReg();
		runRandom();
		repeat (DRAIN_CYCLES) begin
			issue(1'b0, '0);
		end
		repeat (2) @(posedge clk);
		@(negedge clk);

		$display("Checks %0d, errors: wbValid %0d, wbDst %0d, wbData %0d",
			checks, validErrors, dstErrors, dataErrors);
		if (validErrors + dstErrors + dataErrors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+hdl
hdl/corePkg.sv
hdl/registerFile.sv
hdl/instrDecode.sv
hdl/execUnit.sv
hdl/execCore.sv
testbench/execCoreTb.sv

/* Makefile */
# Verilator build and run for the execute core testbench

VERILATOR ?= verilator
TOP       ?= execCoreTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Result: FAILED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

test: build
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; exit 1; \
	fi; \
	echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
